/* hw/axi_down_pkg.sv */
package axi_down_pkg;

    // ******************************
    // Bus widths
    // ******************************
    localparam int ADDR_W        = 32;
    localparam int ID_W          = 4;
    localparam int LEN_W         = 8;
    localparam int RESP_W        = 2;

    localparam int WIDE_DATA_W   = 64;
    localparam int NARROW_DATA_W = 32;
    localparam int WIDE_STRB_W   = WIDE_DATA_W / 8;
    localparam int NARROW_STRB_W = NARROW_DATA_W / 8;

    // Narrow beats per wide beat
    localparam int DOWN_RATIO    = WIDE_DATA_W / NARROW_DATA_W;
    localparam int SLICE_W       = (DOWN_RATIO > 1) ? $clog2(DOWN_RATIO) : 1;

    // Width of the outstanding write counter
    localparam int OUTST_W       = 4;

    typedef enum logic {
        OWNER_M0 = 1'b0,
        OWNER_M1 = 1'b1
    } owner_e;

    typedef enum logic {
        SER_IDLE = 1'b0,
        SER_SEND = 1'b1
    } ser_state_e;

endpackage

/* hw/axi_wr_if.sv */
`timescale 1ns/1ps

interface axi_wr_if #(
    parameter int DATA_W = axi_down_pkg::WIDE_DATA_W
);
    // Write address channel
    logic                              awvalid;
    logic                              awready;
    logic [axi_down_pkg::ID_W-1:0]     awid;
    logic [axi_down_pkg::ADDR_W-1:0]   awaddr;
    logic [axi_down_pkg::LEN_W-1:0]    awlen;

    // Write data channel
    logic                              wvalid;
    logic                              wready;
    logic [DATA_W-1:0]                 wdata;
    logic [DATA_W/8-1:0]               wstrb;
    logic                              wlast;

    // Write response channel
    logic                              bvalid;
    logic                              bready;
    logic [axi_down_pkg::ID_W-1:0]     bid;
    logic [axi_down_pkg::RESP_W-1:0]   bresp;

    modport mstr (
        output awvalid, awid, awaddr, awlen,
        output wvalid, wdata, wstrb, wlast,
        output bready,
        input  awready, wready, bvalid, bid, bresp
    );

    modport slv (
        input  awvalid, awid, awaddr, awlen,
        input  wvalid, wdata, wstrb, wlast,
        input  bready,
        output awready, wready, bvalid, bid, bresp
    );

endinterface

/* hw/master_select.sv */
`timescale 1ns/1ps

module master_select (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  mstr_sel_i,

    // Master 0
    input  logic                                  m0_awvalid_i,
    output logic                                  m0_awready_o,
    input  logic [axi_down_pkg::ID_W-1:0]         m0_awid_i,
    input  logic [axi_down_pkg::ADDR_W-1:0]       m0_awaddr_i,
    input  logic [axi_down_pkg::LEN_W-1:0]        m0_awlen_i,
    input  logic                                  m0_wvalid_i,
    output logic                                  m0_wready_o,
    input  logic [axi_down_pkg::WIDE_DATA_W-1:0]  m0_wdata_i,
    input  logic [axi_down_pkg::WIDE_STRB_W-1:0]  m0_wstrb_i,
    input  logic                                  m0_wlast_i,
    output logic                                  m0_bvalid_o,
    input  logic                                  m0_bready_i,
    output logic [axi_down_pkg::ID_W-1:0]         m0_bid_o,
    output logic [axi_down_pkg::RESP_W-1:0]       m0_bresp_o,

    // Master 1
    input  logic                                  m1_awvalid_i,
    output logic                                  m1_awready_o,
    input  logic [axi_down_pkg::ID_W-1:0]         m1_awid_i,
    input  logic [axi_down_pkg::ADDR_W-1:0]       m1_awaddr_i,
    input  logic [axi_down_pkg::LEN_W-1:0]        m1_awlen_i,
    input  logic                                  m1_wvalid_i,
    output logic                                  m1_wready_o,
    input  logic [axi_down_pkg::WIDE_DATA_W-1:0]  m1_wdata_i,
    input  logic [axi_down_pkg::WIDE_STRB_W-1:0]  m1_wstrb_i,
    input  logic                                  m1_wlast_i,
    output logic                                  m1_bvalid_o,
    input  logic                                  m1_bready_i,
    output logic [axi_down_pkg::ID_W-1:0]         m1_bid_o,
    output logic [axi_down_pkg::RESP_W-1:0]       m1_bresp_o,

    axi_wr_if.mstr                                bus_o
);

    axi_down_pkg::owner_e                owner_q;
    logic [axi_down_pkg::OUTST_W-1:0]    outst_cnt_q;
    logic                                own_m1;
    logic                                cnt_full;
    logic                                aw_hs;
    logic                                b_hs;

    assign own_m1   = (owner_q == axi_down_pkg::OWNER_M1);
    assign cnt_full = &outst_cnt_q;
    assign aw_hs    = bus_o.awvalid & bus_o.awready;
    assign b_hs     = bus_o.bvalid & bus_o.bready;

    // ******************************
    // Ownership and outstanding bursts
    // ******************************
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            owner_q <= axi_down_pkg::OWNER_M0;
        end else if (outst_cnt_q == '0 && !aw_hs) begin
            owner_q <= axi_down_pkg::owner_e'(mstr_sel_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outst_cnt_q <= '0;
        end else begin
            case ({aw_hs, b_hs})
                2'b10:   outst_cnt_q <= outst_cnt_q + 1'b1;
                2'b01:   outst_cnt_q <= outst_cnt_q - 1'b1;
                default: outst_cnt_q <= outst_cnt_q;
            endcase
        end
    end

    // ******************************
    // Request mux
    // ******************************
    // AW is held off once the counter is saturated
    assign bus_o.awvalid = (own_m1 ? m1_awvalid_i : m0_awvalid_i) & ~cnt_full;
    assign bus_o.awid    = own_m1 ? m1_awid_i   : m0_awid_i;
    assign bus_o.awaddr  = own_m1 ? m1_awaddr_i : m0_awaddr_i;
    assign bus_o.awlen   = own_m1 ? m1_awlen_i  : m0_awlen_i;
    assign bus_o.wvalid  = own_m1 ? m1_wvalid_i : m0_wvalid_i;
    assign bus_o.wdata   = own_m1 ? m1_wdata_i  : m0_wdata_i;
    assign bus_o.wstrb   = own_m1 ? m1_wstrb_i  : m0_wstrb_i;
    assign bus_o.wlast   = own_m1 ? m1_wlast_i  : m0_wlast_i;
    assign bus_o.bready  = own_m1 ? m1_bready_i : m0_bready_i;

    // Non-owner sees no ready and no response
    assign m0_awready_o = ~own_m1 & bus_o.awready & ~cnt_full;
    assign m1_awready_o =  own_m1 & bus_o.awready & ~cnt_full;
    assign m0_wready_o  = ~own_m1 & bus_o.wready;
    assign m1_wready_o  =  own_m1 & bus_o.wready;
    assign m0_bvalid_o  = ~own_m1 & bus_o.bvalid;
    assign m1_bvalid_o  =  own_m1 & bus_o.bvalid;

    assign m0_bid_o   = bus_o.bid;
    assign m0_bresp_o = bus_o.bresp;
    assign m1_bid_o   = bus_o.bid;
    assign m1_bresp_o = bus_o.bresp;

endmodule

/* hw/aw_convert.sv */
`timescale 1ns/1ps

module aw_convert (
    input  logic                             clk_i,
    input  logic                             reset_i,
    axi_wr_if.slv                            bus_i,
    output logic                             n_awvalid_o,
    input  logic                             n_awready_i,
    output logic [axi_down_pkg::ID_W-1:0]    n_awid_o,
    output logic [axi_down_pkg::ADDR_W-1:0]  n_awaddr_o,
    output logic [axi_down_pkg::LEN_W-1:0]   n_awlen_o
);

    logic         slot_full_q;
    logic         aw_hs;
    logic [31:0]  len_scaled;

    assign bus_i.awready = ~slot_full_q;
    assign aw_hs         = bus_i.awvalid & ~slot_full_q;

    // Narrow beat count is the wide count times the ratio
    assign len_scaled = (32'(bus_i.awlen) + 32'd1) * axi_down_pkg::DOWN_RATIO - 32'd1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slot_full_q <= 1'b0;
        end else if (aw_hs) begin
            slot_full_q <= 1'b1;
        end else if (n_awvalid_o && n_awready_i) begin
            slot_full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            n_awid_o   <= bus_i.awid;
            n_awaddr_o <= bus_i.awaddr;
            n_awlen_o  <= len_scaled[axi_down_pkg::LEN_W-1:0];
        end
    end

    assign n_awvalid_o = slot_full_q;

endmodule

/* hw/w_serialize.sv */
`timescale 1ns/1ps

module w_serialize (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    axi_wr_if.slv                                   bus_i,
    output logic                                    n_wvalid_o,
    input  logic                                    n_wready_i,
    output logic [axi_down_pkg::NARROW_DATA_W-1:0]  n_wdata_o,
    output logic [axi_down_pkg::NARROW_STRB_W-1:0]  n_wstrb_o,
    output logic                                    n_wlast_o
);

    axi_down_pkg::ser_state_e                  state_q;
    logic [axi_down_pkg::SLICE_W-1:0]          slice_q;
    logic [axi_down_pkg::WIDE_DATA_W-1:0]      data_q;
    logic [axi_down_pkg::WIDE_STRB_W-1:0]      strb_q;
    logic                                      last_q;
    logic                                      w_hs;
    logic                                      n_hs;
    logic                                      last_slice;

    assign bus_i.wready = (state_q == axi_down_pkg::SER_IDLE);
    assign w_hs         = bus_i.wvalid & bus_i.wready;
    assign n_wvalid_o   = (state_q == axi_down_pkg::SER_SEND);
    assign n_hs         = n_wvalid_o & n_wready_i;
    assign last_slice   = (32'(slice_q) == axi_down_pkg::DOWN_RATIO - 1);

    // ******************************
    // Slice sequencer
    // ******************************
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= axi_down_pkg::SER_IDLE;
            slice_q <= '0;
        end else begin
            case (state_q)
                axi_down_pkg::SER_IDLE: begin
                    if (w_hs) begin
                        state_q <= axi_down_pkg::SER_SEND;
                        slice_q <= '0;
                    end
                end
                axi_down_pkg::SER_SEND: begin
                    if (n_hs) begin
                        if (last_slice) begin
                            state_q <= axi_down_pkg::SER_IDLE;
                            slice_q <= '0;
                        end else begin
                            slice_q <= slice_q + 1'b1;
                        end
                    end
                end
                default: state_q <= axi_down_pkg::SER_IDLE;
            endcase
        end
    end

    // Wide beat held for the whole serialization
    always_ff @(posedge clk_i) begin
        if (w_hs) begin
            data_q <= bus_i.wdata;
            strb_q <= bus_i.wstrb;
            last_q <= bus_i.wlast;
        end
    end

    // Lower slice first
    assign n_wdata_o = data_q[slice_q * axi_down_pkg::NARROW_DATA_W +: axi_down_pkg::NARROW_DATA_W];
    assign n_wstrb_o = strb_q[slice_q * axi_down_pkg::NARROW_STRB_W +: axi_down_pkg::NARROW_STRB_W];
    assign n_wlast_o = n_wvalid_o & last_q & last_slice;

endmodule

/* hw/axi_down_wrap.sv */
`timescale 1ns/1ps

module axi_down_wrap (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    mstr_sel_i,

    // Master 0, wide
    input  logic                                    m0_awvalid_i,
    output logic                                    m0_awready_o,
    input  logic [axi_down_pkg::ID_W-1:0]           m0_awid_i,
    input  logic [axi_down_pkg::ADDR_W-1:0]         m0_awaddr_i,
    input  logic [axi_down_pkg::LEN_W-1:0]          m0_awlen_i,
    input  logic                                    m0_wvalid_i,
    output logic                                    m0_wready_o,
    input  logic [axi_down_pkg::WIDE_DATA_W-1:0]    m0_wdata_i,
    input  logic [axi_down_pkg::WIDE_STRB_W-1:0]    m0_wstrb_i,
    input  logic                                    m0_wlast_i,
    output logic                                    m0_bvalid_o,
    input  logic                                    m0_bready_i,
    output logic [axi_down_pkg::ID_W-1:0]           m0_bid_o,
    output logic [axi_down_pkg::RESP_W-1:0]         m0_bresp_o,

    // Master 1, wide
    input  logic                                    m1_awvalid_i,
    output logic                                    m1_awready_o,
    input  logic [axi_down_pkg::ID_W-1:0]           m1_awid_i,
    input  logic [axi_down_pkg::ADDR_W-1:0]         m1_awaddr_i,
    input  logic [axi_down_pkg::LEN_W-1:0]          m1_awlen_i,
    input  logic                                    m1_wvalid_i,
    output logic                                    m1_wready_o,
    input  logic [axi_down_pkg::WIDE_DATA_W-1:0]    m1_wdata_i,
    input  logic [axi_down_pkg::WIDE_STRB_W-1:0]    m1_wstrb_i,
    input  logic                                    m1_wlast_i,
    output logic                                    m1_bvalid_o,
    input  logic                                    m1_bready_i,
    output logic [axi_down_pkg::ID_W-1:0]           m1_bid_o,
    output logic [axi_down_pkg::RESP_W-1:0]         m1_bresp_o,

    // Memory controller, narrow
    output logic                                    n_awvalid_o,
    input  logic                                    n_awready_i,
    output logic [axi_down_pkg::ID_W-1:0]           n_awid_o,
    output logic [axi_down_pkg::ADDR_W-1:0]         n_awaddr_o,
    output logic [axi_down_pkg::LEN_W-1:0]          n_awlen_o,
    output logic                                    n_wvalid_o,
    input  logic                                    n_wready_i,
    output logic [axi_down_pkg::NARROW_DATA_W-1:0]  n_wdata_o,
    output logic [axi_down_pkg::NARROW_STRB_W-1:0]  n_wstrb_o,
    output logic                                    n_wlast_o,
    input  logic                                    n_bvalid_i,
    output logic                                    n_bready_o,
    input  logic [axi_down_pkg::ID_W-1:0]           n_bid_i,
    input  logic [axi_down_pkg::RESP_W-1:0]         n_bresp_i
);

    axi_wr_if #(.DATA_W(axi_down_pkg::WIDE_DATA_W)) wide_bus ();

    // ******************************
    // Owner select and downsizer
    // ******************************
    master_select u_master_select (
        .bus_o (wide_bus),
        .*
    );

    aw_convert u_aw_convert (
        .bus_i (wide_bus),
        .*
    );

    w_serialize u_w_serialize (
        .bus_i (wide_bus),
        .*
    );

    // Responses pass straight through
    assign wide_bus.bvalid = n_bvalid_i;
    assign wide_bus.bid    = n_bid_i;
    assign wide_bus.bresp  = n_bresp_i;
    assign n_bready_o      = wide_bus.bready;

endmodule

/* verification/axi_down_assert.sv */
`timescale 1ns/1ps

module axi_down_assert (
    input logic                                    clk_i,
    input logic                                    reset_i,
    input logic                                    awvalid_i,
    input logic                                    awready_i,
    input logic [axi_down_pkg::ID_W+axi_down_pkg::ADDR_W+axi_down_pkg::LEN_W-1:0] aw_payload_i,
    input logic                                    wvalid_i,
    input logic                                    wready_i,
    input logic                                    wlast_i,
    input logic [axi_down_pkg::NARROW_DATA_W+axi_down_pkg::NARROW_STRB_W:0]       w_payload_i,
    input axi_down_pkg::owner_e                    owner_i,
    input logic                                    wide_aw_hs_i,
    input logic                                    b_hs_i
);

    logic [axi_down_pkg::LEN_W:0]     beat_cnt_q;
    logic [axi_down_pkg::OUTST_W-1:0] outst_q;
    logic                             aw_fail = 1'b0;
    logic                             w_fail = 1'b0;
    logic                             wlast_fail = 1'b0;
    logic                             owner_fail = 1'b0;
    logic                             any_fail;

    assign any_fail = aw_fail | w_fail | wlast_fail | owner_fail;

    // Narrow beat index inside the current burst
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            beat_cnt_q <= '0;
        end else if (wvalid_i && wready_i) begin
            beat_cnt_q <= wlast_i ? '0 : beat_cnt_q + 1'b1;
        end
    end

    // Bursts accepted on the wide side and not yet answered
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outst_q <= '0;
        end else if (wide_aw_hs_i && !b_hs_i) begin
            outst_q <= outst_q + 1'b1;
        end else if (b_hs_i && !wide_aw_hs_i) begin
            outst_q <= outst_q - 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_payload_i))
        else begin
            $error("Narrow AW dropped or changed before ready");
            aw_fail = 1'b1;
        end

    w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(w_payload_i))
        else begin
            $error("Narrow W dropped or changed before ready");
            w_fail = 1'b1;
        end

    wlast_odd: assert property (@(posedge clk_i) disable iff (reset_i)
        wvalid_i && wlast_i |-> beat_cnt_q[0])
        else begin
            $error("Narrow wlast on an even beat of the burst");
            wlast_fail = 1'b1;
        end

    owner_lock: assert property (@(posedge clk_i) disable iff (reset_i)
        (outst_q != '0 || wide_aw_hs_i) |=> $stable(owner_i))
        else begin
            $error("Owner changed with bursts outstanding");
            owner_fail = 1'b1;
        end

endmodule

/* verification/tb_axi_down.sv */
`timescale 1ns/1ps

module tb_axi_down;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NW = axi_down_pkg::NARROW_DATA_W;
    localparam int NS = axi_down_pkg::NARROW_STRB_W;

    logic                                  clk_i;
    logic                                  reset_i;
    logic                                  mstr_sel_i;

    logic                                  m0_awvalid_i, m0_awready_o;
    logic [axi_down_pkg::ID_W-1:0]         m0_awid_i, m0_bid_o;
    logic [axi_down_pkg::ADDR_W-1:0]       m0_awaddr_i;
    logic [axi_down_pkg::LEN_W-1:0]        m0_awlen_i;
    logic                                  m0_wvalid_i, m0_wready_o, m0_wlast_i;
    logic [axi_down_pkg::WIDE_DATA_W-1:0]  m0_wdata_i;
    logic [axi_down_pkg::WIDE_STRB_W-1:0]  m0_wstrb_i;
    logic                                  m0_bvalid_o, m0_bready_i;
    logic [axi_down_pkg::RESP_W-1:0]       m0_bresp_o;

    logic                                  m1_awvalid_i, m1_awready_o;
    logic [axi_down_pkg::ID_W-1:0]         m1_awid_i, m1_bid_o;
    logic [axi_down_pkg::ADDR_W-1:0]       m1_awaddr_i;
    logic [axi_down_pkg::LEN_W-1:0]        m1_awlen_i;
    logic                                  m1_wvalid_i, m1_wready_o, m1_wlast_i;
    logic [axi_down_pkg::WIDE_DATA_W-1:0]  m1_wdata_i;
    logic [axi_down_pkg::WIDE_STRB_W-1:0]  m1_wstrb_i;
    logic                                  m1_bvalid_o, m1_bready_i;
    logic [axi_down_pkg::RESP_W-1:0]       m1_bresp_o;

    logic                                  n_awvalid_o, n_awready_i;
    logic [axi_down_pkg::ID_W-1:0]         n_awid_o, n_bid_i;
    logic [axi_down_pkg::ADDR_W-1:0]       n_awaddr_o;
    logic [axi_down_pkg::LEN_W-1:0]        n_awlen_o;
    logic                                  n_wvalid_o, n_wready_i, n_wlast_o;
    logic [NW-1:0]                         n_wdata_o;
    logic [NS-1:0]                         n_wstrb_o;
    logic                                  n_bvalid_i, n_bready_o;
    logic [axi_down_pkg::RESP_W-1:0]       n_bresp_i;

    // Narrow-side record filled by the monitor
    logic [axi_down_pkg::ID_W-1:0]         got_awid[$];
    logic [axi_down_pkg::ADDR_W-1:0]       got_awaddr[$];
    logic [axi_down_pkg::LEN_W-1:0]        got_awlen[$];
    logic [NW-1:0]                         got_wdata[$];
    logic [NS-1:0]                         got_wstrb[$];
    logic                                  got_wlast[$];
    int                                    bursts_done;
    logic                                  b_hs_seen;

    // Expected narrow beats from the test process
    logic [NW-1:0]                         exp_wdata[$];
    logic [NS-1:0]                         exp_wstrb[$];
    logic                                  exp_wlast[$];

    logic                                  bp_en;
    logic [axi_down_pkg::RESP_W-1:0]       resp_val;
    logic                                  exp_owner;
    logic                                  lock_check;
    int                                    cycle_cnt;

    axi_down_wrap dut0 (.*);

    bind axi_down_wrap axi_down_assert u_assert (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .awvalid_i    (n_awvalid_o),
        .awready_i    (n_awready_i),
        .aw_payload_i ({n_awid_o, n_awaddr_o, n_awlen_o}),
        .wvalid_i     (n_wvalid_o),
        .wready_i     (n_wready_i),
        .wlast_i      (n_wlast_o),
        .w_payload_i  ({n_wdata_o, n_wstrb_o, n_wlast_o}),
        .owner_i      (u_master_select.owner_q),
        .wide_aw_hs_i ((m0_awvalid_i && m0_awready_o) || (m1_awvalid_i && m1_awready_o)),
        .b_hs_i       (n_bvalid_i && n_bready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Regression failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ******************************
    // Narrow-side responder
    // ******************************
    initial begin
        bursts_done = 0;
        b_hs_seen   = 1'b0;
        forever begin
            @(negedge clk_i);
            if (!reset_i) begin
                if (n_awvalid_o && n_awready_i) begin
                    got_awid.push_back(n_awid_o);
                    got_awaddr.push_back(n_awaddr_o);
                    got_awlen.push_back(n_awlen_o);
                end
                if (n_wvalid_o && n_wready_i) begin
                    got_wdata.push_back(n_wdata_o);
                    got_wstrb.push_back(n_wstrb_o);
                    got_wlast.push_back(n_wlast_o);
                    if (n_wlast_o) begin
                        bursts_done++;
                    end
                end
                b_hs_seen = n_bvalid_i && n_bready_o;
                // Narrow bready follows the owner's bready
                if (n_bvalid_i) begin
                    check_eq("n_bready_o", 64'(exp_owner ? m1_bready_i : m0_bready_i),
                             64'(n_bready_o));
                end
                // Non-owner never sees a response
                if (exp_owner) begin
                    check_eq("m0_bvalid_o", 64'(0), 64'(m0_bvalid_o));
                end else begin
                    check_eq("m1_bvalid_o", 64'(0), 64'(m1_bvalid_o));
                end
                if (lock_check) begin
                    check_eq("m1_awready_o", 64'(0), 64'(m1_awready_o));
                end
                if (dut0.u_assert.any_fail) begin
                    $display("A bound assertion on the narrow port or owner fired");
                    $display("Regression failed");
                    $fatal(1, "Assertion failure");
                end
            end
        end
    end

    initial begin
        int b_sent;
        b_sent      = 0;
        n_awready_i = 1'b0;
        n_wready_i  = 1'b0;
        n_bvalid_i  = 1'b0;
        n_bid_i     = '0;
        n_bresp_i   = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (!reset_i) begin
                n_awready_i = bp_en ? 1'($urandom) : 1'b1;
                n_wready_i  = bp_en ? 1'($urandom) : 1'b1;
                if (n_bvalid_i && b_hs_seen) begin
                    n_bvalid_i = 1'b0;
                end else if (!n_bvalid_i && bursts_done > b_sent && got_awid.size() > b_sent) begin
                    n_bvalid_i = 1'b1;
                    n_bid_i    = got_awid[b_sent];
                    n_bresp_i  = resp_val;
                    b_sent++;
                end
            end
        end
    end

    // ******************************
    // Wide master tasks
    // ******************************
    task automatic drive_aw(input logic m, input logic [axi_down_pkg::ID_W-1:0] id,
                            input logic [axi_down_pkg::ADDR_W-1:0] addr,
                            input logic [axi_down_pkg::LEN_W-1:0] len);
        if (m) begin
            m1_awvalid_i = 1'b1;
            m1_awid_i    = id;
            m1_awaddr_i  = addr;
            m1_awlen_i   = len;
        end else begin
            m0_awvalid_i = 1'b1;
            m0_awid_i    = id;
            m0_awaddr_i  = addr;
            m0_awlen_i   = len;
        end
    endtask

    task automatic wait_aw(input logic m);
        do begin
            @(negedge clk_i);
        end while (!(m ? m1_awready_o : m0_awready_o));
        @(posedge clk_i);
        #1;
        if (m) begin
            m1_awvalid_i = 1'b0;
        end else begin
            m0_awvalid_i = 1'b0;
        end
    endtask

    task automatic send_w(input logic m, input logic [axi_down_pkg::LEN_W-1:0] len);
        logic [axi_down_pkg::WIDE_DATA_W-1:0] data;
        logic [axi_down_pkg::WIDE_STRB_W-1:0] strb;
        logic                                 last;
        for (int i = 0; i <= int'(len); i++) begin
            data = {$urandom, $urandom};
            strb = 8'($urandom);
            last = (i == int'(len));
            // Lower slice goes out first
            for (int k = 0; k < axi_down_pkg::DOWN_RATIO; k++) begin
                exp_wdata.push_back(data[k*NW +: NW]);
                exp_wstrb.push_back(strb[k*NS +: NS]);
                exp_wlast.push_back(last && (k == axi_down_pkg::DOWN_RATIO - 1));
            end
            if (m) begin
                m1_wvalid_i = 1'b1;
                m1_wdata_i  = data;
                m1_wstrb_i  = strb;
                m1_wlast_i  = last;
            end else begin
                m0_wvalid_i = 1'b1;
                m0_wdata_i  = data;
                m0_wstrb_i  = strb;
                m0_wlast_i  = last;
            end
            do begin
                @(negedge clk_i);
            end while (!(m ? m1_wready_o : m0_wready_o));
            @(posedge clk_i);
            #1;
        end
        m0_wvalid_i = 1'b0;
        m1_wvalid_i = 1'b0;
    endtask

    task automatic wait_b(input logic m, input logic [axi_down_pkg::ID_W-1:0] id);
        logic                            bvalid;
        logic [axi_down_pkg::ID_W-1:0]   bid;
        logic [axi_down_pkg::RESP_W-1:0] bresp;
        bvalid = 1'b0;
        while (!bvalid) begin
            @(negedge clk_i);
            bvalid = m ? m1_bvalid_o : m0_bvalid_o;
        end
        bid   = m ? m1_bid_o : m0_bid_o;
        bresp = m ? m1_bresp_o : m0_bresp_o;
        check_eq("bid", 64'(id), 64'(bid));
        check_eq("bresp", 64'(resp_val), 64'(bresp));
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_burst(input logic [axi_down_pkg::ID_W-1:0] id,
                               input logic [axi_down_pkg::ADDR_W-1:0] addr,
                               input logic [axi_down_pkg::LEN_W-1:0] len,
                               input int aw_base, input int w_base);
        logic [axi_down_pkg::LEN_W-1:0] exp_len;
        exp_len = 8'((int'(len) + 1) * axi_down_pkg::DOWN_RATIO - 1);
        check_eq("narrow AW count", 64'(aw_base + 1), 64'(got_awid.size()));
        check_eq("n_awid_o", 64'(id), 64'(got_awid[aw_base]));
        check_eq("n_awaddr_o", 64'(addr), 64'(got_awaddr[aw_base]));
        check_eq("n_awlen_o", 64'(exp_len), 64'(got_awlen[aw_base]));
        check_eq("narrow W count", 64'(exp_wdata.size()), 64'(got_wdata.size() - w_base));
        for (int i = 0; i < exp_wdata.size(); i++) begin
            check_eq("n_wdata_o", 64'(exp_wdata[i]), 64'(got_wdata[w_base + i]));
            check_eq("n_wstrb_o", 64'(exp_wstrb[i]), 64'(got_wstrb[w_base + i]));
            check_eq("n_wlast_o", 64'(exp_wlast[i]), 64'(got_wlast[w_base + i]));
        end
        exp_wdata.delete();
        exp_wstrb.delete();
        exp_wlast.delete();
    endtask

    task automatic write_burst(input logic m, input logic [axi_down_pkg::ID_W-1:0] id,
                               input logic [axi_down_pkg::ADDR_W-1:0] addr,
                               input logic [axi_down_pkg::LEN_W-1:0] len);
        int aw_base;
        int w_base;
        aw_base = got_awid.size();
        w_base  = got_wdata.size();
        drive_aw(m, id, addr, len);
        wait_aw(m);
        send_w(m, len);
        wait_b(m, id);
        check_burst(id, addr, len, aw_base, w_base);
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic test_single_m0();
        mstr_sel_i = 1'b0;
        exp_owner  = 1'b0;
        write_burst(1'b0, 4'h3, 32'h0000_1000, 8'd0);
    endtask

    task automatic test_burst_m1();
        mstr_sel_i = 1'b1;
        exp_owner  = 1'b1;
        write_burst(1'b1, 4'h5, 32'h2000_0040, 8'd3);
    endtask

    task automatic test_backpressure();
        bp_en = 1'b1;
        write_burst(1'b1, 4'h6, 32'h2000_0100, 8'd3);
        bp_en = 1'b0;
    endtask

    task automatic test_b_routing();
        mstr_sel_i  = 1'b0;
        exp_owner   = 1'b0;
        resp_val    = 2'd2;
        // Idle master refuses responses
        m1_bready_i = 1'b0;
        write_burst(1'b0, 4'hA, 32'h0000_3000, 8'd1);
        m1_bready_i = 1'b1;
        resp_val    = 2'd0;
    endtask

    task automatic test_owner_lock();
        int aw_base;
        int w_base;
        aw_base = got_awid.size();
        w_base  = got_wdata.size();
        drive_aw(1'b0, 4'h1, 32'h0000_4000, 8'd2);
        wait_aw(1'b0);
        // Request a switch while M0 still has a burst in flight
        mstr_sel_i = 1'b1;
        lock_check = 1'b1;
        drive_aw(1'b1, 4'h9, 32'h2000_4000, 8'd1);
        send_w(1'b0, 8'd2);
        wait_b(1'b0, 4'h1);
        lock_check = 1'b0;
        check_burst(4'h1, 32'h0000_4000, 8'd2, aw_base, w_base);
        exp_owner = 1'b1;
        aw_base   = got_awid.size();
        w_base    = got_wdata.size();
        wait_aw(1'b1);
        send_w(1'b1, 8'd1);
        wait_b(1'b1, 4'h9);
        check_burst(4'h9, 32'h2000_4000, 8'd1, aw_base, w_base);
    endtask

    initial begin
        void'($urandom(35));
        reset_i      = 1'b1;
        mstr_sel_i   = 1'b0;
        bp_en        = 1'b0;
        resp_val     = 2'd0;
        exp_owner    = 1'b0;
        lock_check   = 1'b0;
        m0_awvalid_i = 1'b0;
        m0_awid_i    = '0;
        m0_awaddr_i  = '0;
        m0_awlen_i   = '0;
        m0_wvalid_i  = 1'b0;
        m0_wdata_i   = '0;
        m0_wstrb_i   = '0;
        m0_wlast_i   = 1'b0;
        m0_bready_i  = 1'b1;
        m1_awvalid_i = 1'b0;
        m1_awid_i    = '0;
        m1_awaddr_i  = '0;
        m1_awlen_i   = '0;
        m1_wvalid_i  = 1'b0;
        m1_wdata_i   = '0;
        m1_wstrb_i   = '0;
        m1_wlast_i   = 1'b0;
        m1_bready_i  = 1'b1;
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        test_single_m0();
        test_burst_m1();
        test_backpressure();
        test_b_routing();
        test_owner_lock();
        repeat (5) @(posedge clk_i);
        if (dut0.u_assert.any_fail == 1'b0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Assertion failure");
        end
    end

    // Watchdog well above the length of the tests
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

endmodule

/* all.f */
hw/axi_down_pkg.sv
hw/axi_wr_if.sv
hw/master_select.sv
hw/aw_convert.sv
hw/w_serialize.sv
hw/axi_down_wrap.sv
verification/axi_down_assert.sv
verification/tb_axi_down.sv

/* Makefile */
SIM = obj_dir/Vtb_axi_down
SRCS = $(wildcard hw/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_axi_down -f all.f -o Vtb_axi_down

sim.log: $(SIM)
	./$(SIM) +verilator+error+limit+10 > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
